// ==== common/issue_macros.svh ====
`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

// Physical register file
`define PHYS_REG_SZ   64
`define PHYS_IDX_BITS 6
`define XLEN          32

// Registers 0..ARCH_INIT-1 come out of reset complete, holding their own index
`define ARCH_INIT     32

// Reservation station
`define RS_SZ         8
`define RS_IDX_BITS   3

// Functional units and result bus
`define NUM_FU_ALU    2
`define NUM_FU_MULT   1
`define CDB_SZ        2
`define MULT_CYCLES   4

// Two source reads per functional unit
`define NUM_READ_PORTS (2 * `NUM_FU_ALU + 2 * `NUM_FU_MULT)

`endif

// ==== common/issue_pkg.sv ====
`include "issue_macros.svh"

package issue_pkg;

    typedef logic [`PHYS_IDX_BITS-1:0] phys_tag_t;
    typedef logic [`XLEN-1:0]          data_t;

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_type_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5
    } alu_func_t;

    // Operand B word, a register tag or an immediate
    // opb_select high means the imm view is the live one
    typedef union packed {
        struct packed {
            logic [`XLEN-`PHYS_IDX_BITS-1:0] pad;
            phys_tag_t                       tag;
        } reg_view;
        data_t imm;
    } opb_field_t;

    typedef struct packed {
        logic       valid;
        fu_type_t   fu_type;
        alu_func_t  alu_func;
        logic       opb_select;
        phys_tag_t  src1;
        logic       src1_ready;
        opb_field_t opb;
        logic       src2_ready;
        phys_tag_t  dest;
    } rs_entry_t;

    typedef struct packed {
        logic      valid;
        alu_func_t alu_func;
        phys_tag_t dest;
        data_t     opa;
        data_t     opb;
    } fu_packet_t;

endpackage

// ==== source/psel_gen.sv ====
`timescale 1ns/100ps

// Lowest-index-first selector, one grant per row
module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]           req,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
    output logic [WIDTH-1:0]           gnt
);

    always_comb begin
        logic [WIDTH-1:0] remaining;
        remaining = req;
        for (int r = 0; r < REQS; r++) begin
            // Isolate the lowest request still waiting
            gnt_bus[r] = remaining & (~remaining + 1'b1);
            remaining  = remaining & ~gnt_bus[r];
        end
        // Whatever got taken off the request vector was granted
        gnt = req & ~remaining;
    end

endmodule

// ==== source/phys_regfile.sv ====
`timescale 1ns/100ps
`include "issue_macros.svh"

module phys_regfile (
    input  logic                                        clock,
    input  logic                                        reset,
    input  issue_pkg::phys_tag_t [`NUM_READ_PORTS-1:0]  read_tags,
    output issue_pkg::data_t     [`NUM_READ_PORTS-1:0]  read_data,
    input  logic                 [`CDB_SZ-1:0]          cdb_valid,
    input  issue_pkg::phys_tag_t [`CDB_SZ-1:0]          cdb_tag,
    input  issue_pkg::data_t     [`CDB_SZ-1:0]          cdb_value,
    output logic                 [`PHYS_REG_SZ-1:0]     complete_list
);
    import issue_pkg::*;

    data_t regs [`PHYS_REG_SZ];

    // Plain combinational read, CDB forwarding is handled in issue select
    always_comb begin
        for (int r = 0; r < `NUM_READ_PORTS; r++) begin
            read_data[r] = regs[read_tags[r]];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < `PHYS_REG_SZ; p++) begin
                regs[p]          <= (p < `ARCH_INIT) ? data_t'(p) : '0;
                complete_list[p] <= (p < `ARCH_INIT);
            end
        end else begin
            for (int l = 0; l < `CDB_SZ; l++) begin
                if (cdb_valid[l]) begin
                    regs[cdb_tag[l]]          <= cdb_value[l];
                    complete_list[cdb_tag[l]] <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== issue/reservation_station.sv ====
`timescale 1ns/100ps
`include "issue_macros.svh"

module reservation_station (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 dispatch_valid,
    input  issue_pkg::fu_type_t                  dispatch_fu_type,
    input  issue_pkg::alu_func_t                 dispatch_alu_func,
    input  issue_pkg::phys_tag_t                 dispatch_src1,
    input  logic                                 dispatch_opb_select,
    input  issue_pkg::opb_field_t                dispatch_opb,
    input  issue_pkg::phys_tag_t                 dispatch_dest,
    input  logic                 [`PHYS_REG_SZ-1:0] complete_list,
    input  logic                 [`CDB_SZ-1:0]   cdb_valid,
    input  issue_pkg::phys_tag_t [`CDB_SZ-1:0]   cdb_tag,
    input  logic                 [`RS_SZ-1:0]    rs_issuing,
    output issue_pkg::rs_entry_t [`RS_SZ-1:0]    rs_entries,
    output logic                 [`RS_SZ-1:0]    rs_ready,
    output logic                                 rs_full
);
    import issue_pkg::*;

    logic [`RS_SZ-1:0] free_slots;
    logic [`RS_SZ-1:0] dispatch_slot;
    rs_entry_t         new_entry;

    function automatic logic cdb_hit(phys_tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < `CDB_SZ; l++) begin
            hit |= cdb_valid[l] && (cdb_tag[l] == tag);
        end
        return hit;
    endfunction

    // Ready also counts a tag broadcast this very cycle
    always_comb begin
        for (int i = 0; i < `RS_SZ; i++) begin
            free_slots[i] = !rs_entries[i].valid;
            rs_ready[i]   = rs_entries[i].valid
                && (rs_entries[i].src1_ready || cdb_hit(rs_entries[i].src1))
                && (rs_entries[i].src2_ready || cdb_hit(rs_entries[i].opb.reg_view.tag));
        end
    end

    assign rs_full = ~|free_slots;

    psel_gen #(
        .WIDTH(`RS_SZ),
        .REQS (1)
    ) free_psel (
        .req    (free_slots),
        .gnt_bus(),
        .gnt    (dispatch_slot)
    );

    always_comb begin
        new_entry.valid      = 1'b1;
        new_entry.fu_type    = dispatch_fu_type;
        new_entry.alu_func   = dispatch_alu_func;
        new_entry.opb_select = dispatch_opb_select;
        new_entry.src1       = dispatch_src1;
        new_entry.src1_ready = complete_list[dispatch_src1] || cdb_hit(dispatch_src1);
        new_entry.opb        = dispatch_opb;
        // immediates need no wakeup
        new_entry.src2_ready = dispatch_opb_select
            || complete_list[dispatch_opb.reg_view.tag]
            || cdb_hit(dispatch_opb.reg_view.tag);
        new_entry.dest       = dispatch_dest;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RS_SZ; i++) begin
                rs_entries[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < `RS_SZ; i++) begin
                if (cdb_hit(rs_entries[i].src1)) begin
                    rs_entries[i].src1_ready <= 1'b1;
                end
                if (cdb_hit(rs_entries[i].opb.reg_view.tag)) begin
                    rs_entries[i].src2_ready <= 1'b1;
                end
                if (rs_issuing[i]) begin
                    rs_entries[i].valid <= 1'b0;
                end
                // Only a free slot is chosen, so this never collides with an issue
                if (dispatch_valid && dispatch_slot[i]) begin
                    rs_entries[i] <= new_entry;
                end
            end
        end
    end

endmodule

// ==== issue/issue_select.sv ====
`timescale 1ns/100ps
`include "issue_macros.svh"

module issue_select (
    input  logic                                      clock,
    input  logic                                      reset,
    input  issue_pkg::rs_entry_t  [`RS_SZ-1:0]          rs_entries,
    input  logic                  [`RS_SZ-1:0]          rs_ready,
    output logic                  [`RS_SZ-1:0]          rs_issuing,
    input  logic                  [`PHYS_REG_SZ-1:0]    complete_list,
    output issue_pkg::phys_tag_t  [`NUM_READ_PORTS-1:0] read_tags,
    input  issue_pkg::data_t      [`NUM_READ_PORTS-1:0] read_data,
    input  logic                  [`CDB_SZ-1:0]         cdb_valid,
    input  issue_pkg::phys_tag_t  [`CDB_SZ-1:0]         cdb_tag,
    input  issue_pkg::data_t      [`CDB_SZ-1:0]         cdb_value,
    input  logic                                      mult_free,
    input  logic                                      mult_cdb_req,
    output issue_pkg::fu_packet_t [`NUM_FU_ALU-1:0]     alu_packets,
    output issue_pkg::fu_packet_t                     mult_packet
);
    import issue_pkg::*;

    localparam int MULT_PORT = 2 * `NUM_FU_ALU;

    logic [`RS_SZ-1:0]                   alu_req;
    logic [`RS_SZ-1:0]                   mult_req;
    logic [`NUM_FU_ALU-1:0][`RS_SZ-1:0]  alu_gnt_bus;
    logic [`RS_SZ-1:0]                   mult_gnt;
    logic [`CDB_SZ-1:0]                  slot_free;
    logic [`NUM_FU_ALU-1:0][`CDB_SZ-1:0] slot_gnt_bus;
    rs_entry_t [`NUM_FU_ALU-1:0]         alu_pick;
    rs_entry_t                           mult_pick;
    fu_packet_t [`NUM_FU_ALU-1:0]        next_alu;
    fu_packet_t                          next_mult;

    function automatic logic [`RS_IDX_BITS-1:0] encode(logic [`RS_SZ-1:0] onehot);
        logic [`RS_IDX_BITS-1:0] idx;
        idx = '0;
        for (int i = 0; i < `RS_SZ; i++) begin
            if (onehot[i]) begin
                idx = i[`RS_IDX_BITS-1:0];
            end
        end
        return idx;
    endfunction

    // Register file if complete, otherwise the CDB lane carrying the tag
    function automatic data_t operand(phys_tag_t tag, data_t rf_value);
        data_t value;
        value = rf_value;
        if (!complete_list[tag]) begin
            for (int l = 0; l < `CDB_SZ; l++) begin
                if (cdb_valid[l] && cdb_tag[l] == tag) begin
                    value = cdb_value[l];
                end
            end
        end
        return value;
    endfunction

    function automatic fu_packet_t build(rs_entry_t e, logic go, data_t rd_a, data_t rd_b);
        fu_packet_t p;
        p.valid    = go;
        p.alu_func = e.alu_func;
        p.dest     = e.dest;
        p.opa      = operand(e.src1, rd_a);
        p.opb      = e.opb_select ? e.opb.imm : operand(e.opb.reg_view.tag, rd_b);
        return p;
    endfunction

    always_comb begin
        for (int i = 0; i < `RS_SZ; i++) begin
            alu_req[i]  = rs_ready[i] && rs_entries[i].fu_type == FU_ALU;
            mult_req[i] = rs_ready[i] && rs_entries[i].fu_type == FU_MULT && mult_free;
        end
    end

    // Lane 0 is held back when the multiplier finishes two edges out
    assign slot_free = ~{{(`CDB_SZ-1){1'b0}}, mult_cdb_req};

    psel_gen #(.WIDTH(`RS_SZ), .REQS(`NUM_FU_ALU)) alu_psel (
        .req(alu_req), .gnt_bus(alu_gnt_bus), .gnt()
    );

    psel_gen #(.WIDTH(`RS_SZ), .REQS(`NUM_FU_MULT)) mult_psel (
        .req(mult_req), .gnt_bus(), .gnt(mult_gnt)
    );

    psel_gen #(.WIDTH(`CDB_SZ), .REQS(`NUM_FU_ALU)) slot_psel (
        .req(slot_free), .gnt_bus(slot_gnt_bus), .gnt()
    );

    always_comb begin
        rs_issuing               = mult_gnt;
        mult_pick                = rs_entries[encode(mult_gnt)];
        read_tags[MULT_PORT]     = mult_pick.src1;
        read_tags[MULT_PORT + 1] = mult_pick.opb.reg_view.tag;
        next_mult = build(mult_pick, |mult_gnt, read_data[MULT_PORT], read_data[MULT_PORT + 1]);
        for (int a = 0; a < `NUM_FU_ALU; a++) begin
            alu_pick[a]          = rs_entries[encode(alu_gnt_bus[a])];
            read_tags[2 * a]     = alu_pick[a].src1;
            read_tags[2 * a + 1] = alu_pick[a].opb.reg_view.tag;
            // An ALU grant only counts if a CDB slot backs it
            next_alu[a] = build(alu_pick[a], |alu_gnt_bus[a] && |slot_gnt_bus[a],
                                read_data[2 * a], read_data[2 * a + 1]);
            if (next_alu[a].valid) begin
                rs_issuing |= alu_gnt_bus[a];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `NUM_FU_ALU; a++) begin
                alu_packets[a].valid <= 1'b0;
            end
            mult_packet.valid <= 1'b0;
        end else begin
            alu_packets <= next_alu;
            mult_packet <= next_mult;
        end
    end

endmodule

// ==== execute/execute_units.sv ====
`timescale 1ns/100ps
`include "issue_macros.svh"

module execute_units (
    input  logic                                    clock,
    input  logic                                    reset,
    input  issue_pkg::fu_packet_t [`NUM_FU_ALU-1:0] alu_packets,
    input  issue_pkg::fu_packet_t                   mult_packet,
    output logic                                    mult_free,
    output logic                                    mult_cdb_req,
    output logic                  [`CDB_SZ-1:0]     cdb_valid,
    output issue_pkg::phys_tag_t  [`CDB_SZ-1:0]     cdb_tag,
    output issue_pkg::data_t      [`CDB_SZ-1:0]     cdb_value
);
    import issue_pkg::*;

    localparam int CNT_BITS   = $clog2(`MULT_CYCLES);
    localparam int SHAMT_BITS = $clog2(`XLEN);

    logic [CNT_BITS-1:0]          mult_count;
    data_t                        mult_a;
    data_t                        mult_b;
    phys_tag_t                    mult_dest;
    logic [`CDB_SZ-1:0]           next_valid;
    phys_tag_t [`CDB_SZ-1:0]      next_tag;
    data_t [`CDB_SZ-1:0]          next_value;

    function automatic data_t alu_result(alu_func_t func, data_t a, data_t b);
        case (func)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[SHAMT_BITS-1:0];
            default: return '0;
        endcase
    endfunction

    // Busy from the packet cycle until the result edge
    assign mult_free    = !mult_packet.valid && mult_count == '0;
    // second to last count, lane 0 is spoken for at the next issue edge
    assign mult_cdb_req = mult_count == CNT_BITS'(`MULT_CYCLES - 2);

    always_ff @(posedge clock) begin
        if (reset) begin
            mult_count <= '0;
        end else if (mult_packet.valid) begin
            mult_count <= CNT_BITS'(`MULT_CYCLES - 1);
        end else if (mult_count != '0) begin
            mult_count <= mult_count - 1'b1;
        end
    end

    // Operands held for the whole count
    always_ff @(posedge clock) begin
        if (mult_packet.valid) begin
            mult_a    <= mult_packet.opa;
            mult_b    <= mult_packet.opb;
            mult_dest <= mult_packet.dest;
        end
    end

    always_comb begin
        int lane;
        lane       = 0;
        next_valid = '0;
        next_tag   = '0;
        next_value = '0;
        if (mult_count == CNT_BITS'(1)) begin
            next_valid[0] = 1'b1;
            next_tag[0]   = mult_dest;
            next_value[0] = mult_a * mult_b;
            lane          = 1;
        end
        // ALUs take the lowest lanes left
        for (int a = 0; a < `NUM_FU_ALU; a++) begin
            if (alu_packets[a].valid && lane < `CDB_SZ) begin
                next_valid[lane] = 1'b1;
                next_tag[lane]   = alu_packets[a].dest;
                next_value[lane] = alu_result(alu_packets[a].alu_func,
                                              alu_packets[a].opa, alu_packets[a].opb);
                lane++;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= '0;
        end else begin
            cdb_valid <= next_valid;
        end
        cdb_tag   <= next_tag;
        cdb_value <= next_value;
    end

endmodule

// ==== source/issue_top.sv ====
`timescale 1ns/100ps
`include "issue_macros.svh"

module issue_top (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   dispatch_valid,
    input  issue_pkg::fu_type_t                    dispatch_fu_type,
    input  issue_pkg::alu_func_t                   dispatch_alu_func,
    input  issue_pkg::phys_tag_t                   dispatch_src1,
    input  logic                                   dispatch_opb_select,
    input  issue_pkg::opb_field_t                  dispatch_opb,
    input  issue_pkg::phys_tag_t                   dispatch_dest,
    output logic                                   rs_full,
    output logic                 [`CDB_SZ-1:0]     cdb_valid,
    output issue_pkg::phys_tag_t [`CDB_SZ-1:0]     cdb_tag,
    output issue_pkg::data_t     [`CDB_SZ-1:0]     cdb_value
);
    import issue_pkg::*;

    logic [`PHYS_REG_SZ-1:0]            complete_list;
    rs_entry_t [`RS_SZ-1:0]             rs_entries;
    logic [`RS_SZ-1:0]                  rs_ready;
    logic [`RS_SZ-1:0]                  rs_issuing;
    phys_tag_t [`NUM_READ_PORTS-1:0]    read_tags;
    data_t [`NUM_READ_PORTS-1:0]        read_data;
    logic                               mult_free;
    logic                               mult_cdb_req;
    fu_packet_t [`NUM_FU_ALU-1:0]       alu_packets;
    fu_packet_t                         mult_packet;

    reservation_station rs0 (
        .clock, .reset, .dispatch_valid, .dispatch_fu_type, .dispatch_alu_func,
        .dispatch_src1, .dispatch_opb_select, .dispatch_opb, .dispatch_dest,
        .complete_list, .cdb_valid, .cdb_tag, .rs_issuing, .rs_entries, .rs_ready, .rs_full
    );

    issue_select sel0 (
        .clock, .reset, .rs_entries, .rs_ready, .rs_issuing, .complete_list,
        .read_tags, .read_data, .cdb_valid, .cdb_tag, .cdb_value,
        .mult_free, .mult_cdb_req, .alu_packets, .mult_packet
    );

    phys_regfile prf0 (
        .clock, .reset, .read_tags, .read_data, .cdb_valid, .cdb_tag, .cdb_value, .complete_list
    );

    execute_units ex0 (
        .clock, .reset, .alu_packets, .mult_packet, .mult_free, .mult_cdb_req,
        .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

// ==== tests/issue_assertions.sv ====
`timescale 1ns/100ps
`include "issue_macros.svh"

module issue_assertions (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    rs_full,
    input  logic                                    mult_free,
    input  logic                  [`CDB_SZ-1:0]     cdb_valid,
    input  issue_pkg::phys_tag_t  [`CDB_SZ-1:0]     cdb_tag,
    input  logic                  [`RS_SZ-1:0]      rs_issuing,
    input  issue_pkg::fu_packet_t                   mult_packet
);
    import issue_pkg::*;

    int fail_count = 0;

    // Quiet bus, empty station and an idle multiplier one edge after reset
    reset_state: assert property (@(posedge clock)
        reset |=> (cdb_valid == '0 && !rs_full && mult_free))
        else begin $error("state after reset is wrong"); fail_count++; end

    distinct_tags: assert property (@(posedge clock) disable iff (reset)
        (&cdb_valid) |-> (cdb_tag[0] != cdb_tag[1]))
        else begin $error("two CDB lanes carry the same tag"); fail_count++; end

    // A full station stays full until an entry issues
    full_flag: assert property (@(posedge clock) disable iff (reset)
        (rs_full && rs_issuing == '0) |=> rs_full)
        else begin $error("rs_full dropped without an entry issuing"); fail_count++; end

    // Only renamed destinations ever get broadcast
    renamed_tags: assert property (@(posedge clock) disable iff (reset)
        (!cdb_valid[0] || cdb_tag[0] >= `ARCH_INIT) && (!cdb_valid[1] || cdb_tag[1] >= `ARCH_INIT))
        else begin $error("CDB broadcasts an architected tag"); fail_count++; end

    mult_on_lane0: assert property (@(posedge clock) disable iff (reset)
        mult_packet.valid |-> ##(`MULT_CYCLES)
            (cdb_valid[0] && cdb_tag[0] == $past(mult_packet.dest, `MULT_CYCLES)))
        else begin $error("multiplier result missing from lane 0"); fail_count++; end

endmodule

bind issue_top issue_assertions chk0 (
    .clock(clock), .reset(reset), .rs_full(rs_full), .mult_free(mult_free),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .rs_issuing(rs_issuing),
    .mult_packet(mult_packet)
);

// ==== tests/issue_tb.sv ====
`timescale 1ns/100ps
`include "issue_macros.svh"

module issue_tb;
    import issue_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic                    clock;
    logic                    reset;
    logic                    dispatch_valid;
    fu_type_t                dispatch_fu_type;
    alu_func_t               dispatch_alu_func;
    phys_tag_t               dispatch_src1;
    logic                    dispatch_opb_select;
    opb_field_t              dispatch_opb;
    phys_tag_t               dispatch_dest;
    logic                    rs_full;
    logic [`CDB_SZ-1:0]      cdb_valid;
    phys_tag_t [`CDB_SZ-1:0] cdb_tag;
    data_t [`CDB_SZ-1:0]     cdb_value;

    // Expected value of every tag, filled in at dispatch
    data_t       model [`PHYS_REG_SZ];
    int          seen [`PHYS_REG_SZ];
    int          dispatch_edge [`PHYS_REG_SZ];
    int          bcast_edge [`PHYS_REG_SZ];
    int          bcast_lane [`PHYS_REG_SZ];
    int          next_tag = `ARCH_INIT;
    int          cycle = 0;
    int          n_dispatched = 0;
    int          n_broadcast = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          errors_before = 0;
    logic        saw_full = 1'b0;
    logic [31:0] rng = 32'hd643;

    issue_top dut0 (.*);

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift(logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic phys_tag_t rand_reg();
        return phys_tag_t'(rand_word() % `ARCH_INIT);
    endfunction

    function automatic data_t expected(fu_type_t fu, alu_func_t fn, data_t a, data_t b);
        if (fu == FU_MULT) begin
            return a * b;
        end
        case (fn)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            default: return '0;
        endcase
    endfunction

    function automatic int total_errors();
        return errors + dut0.chk0.fail_count;
    endfunction

    // Holds the instruction on the inputs until the station takes it
    task automatic dispatch_op(input fu_type_t fu, input alu_func_t fn, input phys_tag_t src1,
                               input logic opb_sel, input logic [31:0] opb_word,
                               output phys_tag_t dest);
        int    waited;
        data_t b;
        dest = phys_tag_t'(next_tag);
        next_tag++;
        b = opb_sel ? opb_word : model[opb_word[`PHYS_IDX_BITS-1:0]];
        model[dest] = expected(fu, fn, model[src1], b);
        dispatch_valid      = 1'b1;
        dispatch_fu_type    = fu;
        dispatch_alu_func   = fn;
        dispatch_src1       = src1;
        dispatch_opb_select = opb_sel;
        dispatch_dest       = dest;
        if (opb_sel) begin
            dispatch_opb.imm = opb_word;
        end else begin
            dispatch_opb.imm          = '0;
            dispatch_opb.reg_view.tag = phys_tag_t'(opb_word);
        end
        waited = 0;
        while (rs_full && waited < WAIT_LIMIT) begin
            saw_full = 1'b1;
            @(negedge clock);
            waited++;
        end
        if (rs_full) begin
            $display("Timeout: dispatch of tag %0d was never accepted", dest);
            errors++;
        end else begin
            dispatch_edge[dest] = cycle + 1;
            n_dispatched++;
        end
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        while (n_broadcast < n_dispatched && waited < WAIT_LIMIT) begin
            @(posedge clock);
            waited++;
        end
        if (n_broadcast < n_dispatched) begin
            $display("Timeout: %s results still missing after %0d cycles", what, waited);
            errors++;
        end
        @(negedge clock);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, total_errors() - errors_before);
        errors_before = total_errors();
    endtask

    // CDB is registered, so the middle of the cycle sees settled values
    always @(negedge clock) begin
        int t;
        if (!reset) begin
            for (int l = 0; l < `CDB_SZ; l++) begin
                if (cdb_valid[l]) begin
                    t = cdb_tag[l];
                    checks++;
                    assert (t >= `ARCH_INIT && t < next_tag && seen[t] == 0) else begin
                        $display("ERR %0t: lane %0d broadcasts unexpected tag %0d", $time, l, t);
                        errors++;
                    end
                    assert (cdb_value[l] === model[t]) else begin
                        $display("ERR %0t: tag %0d value %h, expected %h",
                                 $time, t, cdb_value[l], model[t]);
                        errors++;
                    end
                    seen[t]++;
                    bcast_edge[t] = cycle;
                    bcast_lane[t] = l;
                    n_broadcast++;
                end
            end
        end
    end

    initial begin
        phys_tag_t tag;
        phys_tag_t m0;
        phys_tag_t m1;
        phys_tag_t m2;
        phys_tag_t chain [4];
        int        gap;
        clock               = 1'b0;
        reset               = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_fu_type    = FU_ALU;
        dispatch_alu_func   = ALU_ADD;
        dispatch_src1       = '0;
        dispatch_opb_select = 1'b0;
        dispatch_opb        = '0;
        dispatch_dest       = '0;
        for (int p = 0; p < `PHYS_REG_SZ; p++) begin
            model[p] = (p < `ARCH_INIT) ? data_t'(p) : 'x;
            seen[p]  = 0;
        end
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        finish_test("reset state");

        // Every function, half with an immediate and half with a register
        for (int i = 0; i < 8; i++) begin
            dispatch_op(FU_ALU, alu_func_t'(i % 6), rand_reg(), i[1],
                        i[1] ? rand_word() : rand_reg(), tag);
        end
        drain("ALU");
        finish_test("ALU results");

        // Two dependents of one ALU wake together while lane 0 is reserved for the product
        dispatch_op(FU_MULT, ALU_ADD, rand_reg(), 1'b0, rand_reg(), m0);
        dispatch_op(FU_ALU, ALU_XOR, rand_reg(), 1'b1, rand_word(), tag);
        dispatch_op(FU_ALU, ALU_SUB, tag, 1'b0, rand_reg(), m1);
        dispatch_op(FU_ALU, ALU_OR, tag, 1'b1, rand_word(), m2);
        drain("multiply");
        checks++;
        assert (bcast_lane[m0] == 0 && bcast_edge[m0] == dispatch_edge[m0] + 1 + `MULT_CYCLES)
        else begin
            $display("ERR %0t: multiply lane %0d edge %0d, dispatched at edge %0d",
                     $time, bcast_lane[m0], bcast_edge[m0], dispatch_edge[m0]);
            errors++;
        end
        finish_test("multiply result and lanes");

        dispatch_op(FU_ALU, ALU_ADD, rand_reg(), 1'b1, rand_word() % 256, chain[0]);
        for (int i = 1; i < 4; i++) begin
            dispatch_op(FU_ALU, alu_func_t'(rand_word() % 6), chain[i-1], 1'b0, rand_reg(),
                        chain[i]);
        end
        drain("chain");
        // Each link issues on the edge ending the broadcast that wakes it, then one ALU cycle
        for (int i = 1; i < 4; i++) begin
            checks++;
            assert (bcast_edge[chain[i]] == bcast_edge[chain[i-1]] + 2) else begin
                $display("ERR %0t: chain link %0d broadcast at edge %0d, previous at %0d",
                         $time, i, bcast_edge[chain[i]], bcast_edge[chain[i-1]]);
                errors++;
            end
        end
        finish_test("forwarding chain");

        dispatch_op(FU_MULT, ALU_ADD, rand_reg(), 1'b0, rand_reg(), m0);
        dispatch_op(FU_MULT, ALU_ADD, rand_reg(), 1'b1, rand_word(), m1);
        drain("multiplier pair");
        gap = bcast_edge[m1] - bcast_edge[m0];
        checks++;
        assert (gap >= `MULT_CYCLES || gap <= -`MULT_CYCLES) else begin
            $display("ERR %0t: multiplies broadcast only %0d cycles apart", $time, gap);
            errors++;
        end
        finish_test("multiplier back-pressure");

        // A slow multiply chain keeps its dependents parked until the station fills
        saw_full = 1'b0;
        dispatch_op(FU_MULT, ALU_ADD, rand_reg(), 1'b0, rand_reg(), m0);
        dispatch_op(FU_MULT, ALU_ADD, m0, 1'b0, rand_reg(), m1);
        dispatch_op(FU_MULT, ALU_ADD, m1, 1'b1, rand_word() % 16, m2);
        for (int i = 0; i < 9; i++) begin
            dispatch_op(FU_ALU, alu_func_t'(rand_word() % 6), m2, 1'b1, rand_word(), tag);
        end
        drain("full station");
        checks++;
        assert (saw_full) else begin
            $display("The station never reported full while dependents were waiting");
            errors++;
        end
        finish_test("full station");

        for (int t = `ARCH_INIT; t < next_tag; t++) begin
            checks++;
            assert (seen[t] == 1) else begin
                $display("Tag %0d was broadcast %0d times instead of once", t, seen[t]);
                errors++;
            end
        end
        finish_test("single broadcast per tag");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, total_errors());
        if (total_errors() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+common
common/issue_pkg.sv
source/psel_gen.sv
source/phys_regfile.sv
issue/reservation_station.sv
issue/issue_select.sv
execute/execute_units.sv
source/issue_top.sv
tests/issue_assertions.sv
tests/issue_tb.sv
